/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rvPkg.sv
      - hdl/ctrlIf.sv
      - hdl/ctrlGen.sv
      - hdl/immGen.sv
      - hdl/alu.sv
      - hdl/branchUnit.sv
      - hdl/regFile.sv
      - hdl/rvCore.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/rvCore_props.sv
      - verification/rvCore_tb.sv

/* all.f */
+incdir+hdl
hdl/rvPkg.sv
hdl/ctrlIf.sv
hdl/ctrlGen.sv
hdl/immGen.sv
hdl/alu.sv
hdl/branchUnit.sv
hdl/regFile.sv
hdl/rvCore.sv
verification/rvCore_props.sv
verification/rvCore_tb.sv

/* hdl/alu.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module alu import rvPkg::*; (
    input  wire logic [`XLEN-1:0] a,
    input  wire logic [`XLEN-1:0] b,
    input  wire aluOp_t           op,
    output logic      [`XLEN-1:0] result,
    output logic                  less
);

    localparam int ShW = $clog2(`XLEN);

    logic [ShW-1:0] shamt;
    logic           lessS;
    logic           lessU;

    assign shamt = b[ShW-1:0];
    assign lessS = $signed(a) < $signed(b);
    assign lessU = a < b;

    // unsigned codes pick the unsigned compare, everything else signed
    assign less = (op == aluSltu || op == aluCmpU) ? lessU : lessS;

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluSll:   result = a << shamt;
            aluSrl:   result = a >> shamt;
            aluSra:   result = $signed(a) >>> shamt;
            aluSlt:   result = {{(`XLEN-1){1'b0}}, lessS};
            aluSltu:  result = {{(`XLEN-1){1'b0}}, lessU};
            aluCmpU:  result = {{(`XLEN-1){1'b0}}, lessU};
            aluXor:   result = a ^ b;
            aluOr:    result = a | b;
            aluAnd:   result = a & b;
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/branchUnit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module branchUnit import rvPkg::*; (
    input  wire logic [`XLEN-1:0] pc,
    input  wire logic [`XLEN-1:0] imm,
    input  wire logic [`XLEN-1:0] rs1Data,
    input  wire logic [`XLEN-1:0] aluResult,
    input  wire logic             less,
    ctrlIf.datapath               ctrl,
    output logic      [`XLEN-1:0] pcNext
);

    logic             taken;
    logic [`XLEN-1:0] jalrTarget;

    always_comb begin
        case (ctrl.branch)
            brJal:   taken = 1'b1;
            // eq/ne look at the subtract result
            brEq:    taken = (aluResult == '0);
            brNe:    taken = (aluResult != '0);
            brLt:    taken = less;
            brGe:    taken = ~less;
            default: taken = 1'b0;
        endcase
    end

    assign jalrTarget = (rs1Data + imm) & ~`XLEN'(1);

    always_comb begin
        if (ctrl.branch == brJalr) begin
            pcNext = jalrTarget;
        end else if (taken) begin
            pcNext = pc + imm;
        end else begin
            pcNext = pc + `XLEN'(4);
        end
    end

endmodule

`default_nettype wire

/* hdl/ctrlGen.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrlGen import rvPkg::*; (
    input  wire logic [31:0] inst,
    ctrlIf.decoder           ctrl
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        // defaults describe a harmless no-op
        ctrl.extKind   = extR;
        ctrl.regWr     = 1'b0;
        ctrl.aluAsrcPc = 1'b0;
        ctrl.aluBsrc   = bRs2;
        ctrl.aluOp     = aluAdd;
        ctrl.branch    = brNone;
        ctrl.memToReg  = 1'b0;
        ctrl.memWr     = 1'b0;
        ctrl.memRd     = 1'b0;
        ctrl.memOp     = memByte;
        ctrl.illegal   = 1'b0;
        ctrl.halt      = 1'b0;

        case (opcode)
            opReg: begin
                ctrl.aluOp = aluOp_t'({funct7[5], funct7[0], funct3});
                // funct7[0] selects M-extension ops, not supported here
                ctrl.regWr   = ~funct7[0];
                ctrl.illegal = funct7[0];
            end
            opImm: begin
                ctrl.extKind = extI;
                ctrl.regWr   = 1'b1;
                ctrl.aluBsrc = bImm;
                // only srai keeps funct7[5]
                if (funct3 == 3'b101 && funct7[5]) begin
                    ctrl.aluOp = aluOp_t'({2'b10, funct3});
                end else begin
                    ctrl.aluOp = aluOp_t'({2'b00, funct3});
                end
            end
            opLoad: begin
                ctrl.extKind  = extI;
                ctrl.regWr    = 1'b1;
                ctrl.aluBsrc  = bImm;
                ctrl.memToReg = 1'b1;
                ctrl.memRd    = 1'b1;
                ctrl.memOp    = memOp_t'(funct3);
            end
            opJalr: begin
                // alu builds the link value pc + 4
                ctrl.extKind   = extI;
                ctrl.regWr     = 1'b1;
                ctrl.aluAsrcPc = 1'b1;
                ctrl.aluBsrc   = bFour;
                ctrl.branch    = brJalr;
            end
            opStore: begin
                ctrl.extKind = extS;
                ctrl.aluBsrc = bImm;
                ctrl.memWr   = 1'b1;
                ctrl.memOp   = memOp_t'(funct3);
            end
            opBranch: begin
                ctrl.extKind = extB;
                case (funct3)
                    3'b000: begin
                        ctrl.branch = brEq;
                        ctrl.aluOp  = aluSub;
                    end
                    3'b001: begin
                        ctrl.branch = brNe;
                        ctrl.aluOp  = aluSub;
                    end
                    3'b100: begin
                        ctrl.branch = brLt;
                        ctrl.aluOp  = aluSlt;
                    end
                    3'b101: begin
                        ctrl.branch = brGe;
                        ctrl.aluOp  = aluSlt;
                    end
                    3'b110: begin
                        ctrl.branch = brLt;
                        ctrl.aluOp  = aluCmpU;
                    end
                    3'b111: begin
                        ctrl.branch = brGe;
                        ctrl.aluOp  = aluCmpU;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            opLui, opAuipc: begin
                ctrl.extKind   = extU;
                ctrl.regWr     = 1'b1;
                ctrl.aluAsrcPc = 1'b1;
                ctrl.aluBsrc   = bImm;
                ctrl.aluOp     = (opcode == opLui) ? aluPassB : aluAdd;
            end
            opJal: begin
                ctrl.extKind   = extJ;
                ctrl.regWr     = 1'b1;
                ctrl.aluAsrcPc = 1'b1;
                ctrl.aluBsrc   = bFour;
                ctrl.branch    = brJal;
            end
            // ebreak and friends stop the core
            opSystem: ctrl.halt = 1'b1;
            default:  ctrl.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/ctrlIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface ctrlIf import rvPkg::*; ();

    extKind_t    extKind;
    logic        regWr;
    logic        aluAsrcPc;
    aluBsrc_t    aluBsrc;
    aluOp_t      aluOp;
    branchKind_t branch;
    logic        memToReg;
    logic        memWr;
    logic        memRd;
    memOp_t      memOp;
    logic        illegal;
    logic        halt;

    modport decoder (
        output extKind, regWr, aluAsrcPc, aluBsrc, aluOp, branch,
        output memToReg, memWr, memRd, memOp, illegal, halt
    );

    modport datapath (
        input extKind, regWr, aluAsrcPc, aluBsrc, aluOp, branch,
        input memToReg, memWr, memRd, memOp, illegal, halt
    );

endinterface

`default_nettype wire

/* hdl/immGen.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module immGen import rvPkg::*; (
    input  wire logic [31:0]       inst,
    ctrlIf.datapath                ctrl,
    output logic      [`XLEN-1:0] imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (ctrl.extKind)
            extI: imm = {{(`XLEN-12){sign}}, inst[31:20]};
            extS: imm = {{(`XLEN-12){sign}}, inst[31:25], inst[11:7]};
            // branch offsets are in units of two bytes
            extB: imm = {{(`XLEN-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            extU: imm = {{(`XLEN-32){sign}}, inst[31:12], 12'b0};
            extJ: begin
                imm = {{(`XLEN-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module regFile (
    input  wire logic                   clk,
    input  wire logic                   arstN,
    input  wire logic [`REG_ADDR_W-1:0] rs1Addr,
    input  wire logic [`REG_ADDR_W-1:0] rs2Addr,
    input  wire logic                   wrEn,
    input  wire logic [`REG_ADDR_W-1:0] wrAddr,
    input  wire logic [`XLEN-1:0]       wrData,
    output logic      [`XLEN-1:0]       rs1Data,
    output logic      [`XLEN-1:0]       rs2Data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // x0 always reads as zero
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

/* hdl/rvCore.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module rvCore import rvPkg::*; (
    input  wire logic                   clk,
    input  wire logic                   arstN,
    input  wire logic                   instValid,
    input  wire logic [31:0]            inst,
    input  wire logic [`XLEN-1:0]       pc,
    input  wire logic [`XLEN-1:0]       loadData,
    output logic                        resValid,
    output logic      [`XLEN-1:0]       pcNext,
    output logic                        wbEn,
    output logic      [`REG_ADDR_W-1:0] wbAddr,
    output logic      [`XLEN-1:0]       wbData,
    output logic                        memWrEn,
    output logic                        memRdEn,
    output logic      [`XLEN-1:0]       memAddr,
    output logic      [`XLEN-1:0]       memWdata,
    output logic      [2:0]             memFmt,
    output logic                        illegal,
    output logic                        halt
);

    logic [`REG_ADDR_W-1:0] rs1Addr;
    logic [`REG_ADDR_W-1:0] rs2Addr;
    logic [`REG_ADDR_W-1:0] rdAddr;
    logic [`XLEN-1:0]       rs1Data;
    logic [`XLEN-1:0]       rs2Data;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       aluA;
    logic [`XLEN-1:0]       aluB;
    logic [`XLEN-1:0]       aluResult;
    logic                   aluLess;
    logic [`XLEN-1:0]       nextPc;
    logic [`XLEN-1:0]       loadExt;
    logic [`XLEN-1:0]       wrData;
    logic                   wrEn;

    ctrlIf ctrl ();

    assign rs1Addr = inst[19:15];
    assign rs2Addr = inst[24:20];
    assign rdAddr  = inst[11:7];

    ctrlGen uCtrlGen (.inst(inst), .ctrl(ctrl));

    immGen uImmGen (.inst(inst), .ctrl(ctrl), .imm(imm));

    regFile uRegFile (
        .clk(clk), .arstN(arstN),
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
        .wrEn(wrEn), .wrAddr(rdAddr), .wrData(wrData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    // operand selection
    assign aluA = ctrl.aluAsrcPc ? pc : rs1Data;

    always_comb begin
        case (ctrl.aluBsrc)
            bImm:    aluB = imm;
            bFour:   aluB = `XLEN'(4);
            default: aluB = rs2Data;
        endcase
    end

    alu uAlu (.a(aluA), .b(aluB), .op(ctrl.aluOp), .result(aluResult), .less(aluLess));

    branchUnit uBranch (
        .pc(pc), .imm(imm), .rs1Data(rs1Data), .aluResult(aluResult),
        .less(aluLess), .ctrl(ctrl), .pcNext(nextPc)
    );

    // load data arrives right aligned from the memory side
    always_comb begin
        case (ctrl.memOp)
            memByte:  loadExt = {{(`XLEN-8){loadData[7]}}, loadData[7:0]};
            memHalf:  loadExt = {{(`XLEN-16){loadData[15]}}, loadData[15:0]};
            memByteU: loadExt = {{(`XLEN-8){1'b0}}, loadData[7:0]};
            memHalfU: loadExt = {{(`XLEN-16){1'b0}}, loadData[15:0]};
            default:  loadExt = loadData;
        endcase
    end

    assign wrData = ctrl.memToReg ? loadExt : aluResult;

    // x0 writes never reach the result record
    assign wrEn = instValid & ctrl.regWr & (rdAddr != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resValid <= 1'b0;
            wbEn     <= 1'b0;
            memWrEn  <= 1'b0;
            memRdEn  <= 1'b0;
            illegal  <= 1'b0;
            halt     <= 1'b0;
        end else begin
            resValid <= instValid;
            wbEn     <= wrEn;
            memWrEn  <= instValid & ctrl.memWr;
            memRdEn  <= instValid & ctrl.memRd;
            illegal  <= instValid & ctrl.illegal;
            halt     <= instValid & ctrl.halt;
        end
    end

    // result payload, captured with each instruction
    always_ff @(posedge clk) begin
        if (instValid) begin
            pcNext   <= nextPc;
            wbAddr   <= rdAddr;
            wbData   <= wrData;
            memAddr  <= aluResult;
            memWdata <= rs2Data;
            memFmt   <= ctrl.memOp;
        end
    end

endmodule

`default_nettype wire

/* hdl/rvPkg.sv */
`default_nettype none

package rvPkg;

    // major opcodes of RV32I
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opAuipc  = 7'b0010111,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111,
        opSystem = 7'b1110011
    } opcode_t;

    // immediate formats
    typedef enum logic [2:0] {
        extI = 3'b000,
        extU = 3'b001,
        extS = 3'b010,
        extB = 3'b011,
        extJ = 3'b100,
        extR = 3'b111
    } extKind_t;

    // {funct7[5], funct7[0], funct3} plus two extra codes
    typedef enum logic [4:0] {
        aluAdd   = 5'b00000,
        aluSll   = 5'b00001,
        aluSlt   = 5'b00010,
        aluSltu  = 5'b00011,
        aluXor   = 5'b00100,
        aluSrl   = 5'b00101,
        aluOr    = 5'b00110,
        aluAnd   = 5'b00111,
        aluSub   = 5'b10000,
        aluCmpU  = 5'b10010,
        aluSra   = 5'b10101,
        aluPassB = 5'b11000
    } aluOp_t;

    typedef enum logic [1:0] {
        bRs2  = 2'b00,
        bImm  = 2'b01,
        bFour = 2'b10
    } aluBsrc_t;

    typedef enum logic [2:0] {
        brNone = 3'b000,
        brJal  = 3'b001,
        brJalr = 3'b010,
        brEq   = 3'b100,
        brNe   = 3'b101,
        brLt   = 3'b110,
        brGe   = 3'b111
    } branchKind_t;

    // load/store format, same encoding as funct3
    typedef enum logic [2:0] {
        memByte  = 3'b000,
        memHalf  = 3'b001,
        memWord  = 3'b010,
        memByteU = 3'b100,
        memHalfU = 3'b101
    } memOp_t;

endpackage

`default_nettype wire

/* hdl/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path width
`define XLEN 32

// integer register file size
`define REG_COUNT 32
`define REG_ADDR_W 5

`endif

/* verification/rvCore_input.txt */
# id inst pc loadData | expected: pcNext wbEn wbAddr wbData memWrEn memAddr illegal halt
# id, wbEn, wbAddr, memWrEn, illegal, halt in decimal; all other columns in hex
1 00500093 00000100 00000000 00000104 1 1 00000005 0 00000000 0 0
2 FFD00113 00000104 00000000 00000108 1 2 FFFFFFFD 0 00000000 0 0
3 002081B3 00000108 00000000 0000010C 1 3 00000002 0 00000000 0 0
4 40208233 0000010C 00000000 00000110 1 4 00000008 0 00000000 0 0
5 0020C2B3 00000110 00000000 00000114 1 5 FFFFFFF8 0 00000000 0 0
6 00309333 00000114 00000000 00000118 1 6 00000014 0 00000000 0 0
7 003153B3 00000118 00000000 0000011C 1 7 3FFFFFFF 0 00000000 0 0
8 40315433 0000011C 00000000 00000120 1 8 FFFFFFFF 0 00000000 0 0
9 001124B3 00000120 00000000 00000124 1 9 00000001 0 00000000 0 0
10 00113533 00000124 00000000 00000128 1 10 00000000 0 00000000 0 0
11 123455B7 00000128 00000000 0000012C 1 11 12345000 0 00000000 0 0
12 00001617 0000012C 00000000 00000130 1 12 0000112C 0 00000000 0 0
13 00108863 00000200 00000000 00000210 0 0 00000000 0 00000000 0 0
14 00208863 00000204 00000000 00000208 0 0 00000000 0 00000000 0 0
15 00209863 00000208 00000000 00000218 0 0 00000000 0 00000000 0 0
16 00109863 0000020C 00000000 00000210 0 0 00000000 0 00000000 0 0
17 00114863 00000210 00000000 00000220 0 0 00000000 0 00000000 0 0
18 0020C863 00000214 00000000 00000218 0 0 00000000 0 00000000 0 0
19 0020D863 00000218 00000000 00000228 0 0 00000000 0 00000000 0 0
20 00115863 0000021C 00000000 00000220 0 0 00000000 0 00000000 0 0
21 0020E863 00000220 00000000 00000230 0 0 00000000 0 00000000 0 0
22 00116863 00000224 00000000 00000228 0 0 00000000 0 00000000 0 0
23 00117863 00000228 00000000 00000238 0 0 00000000 0 00000000 0 0
24 0020F863 0000022C 00000000 00000230 0 0 00000000 0 00000000 0 0
25 FE000CE3 00000230 00000000 00000228 0 0 00000000 0 00000000 0 0
26 020006EF 00000300 00000000 00000320 1 13 00000304 0 00000000 0 0
27 00608767 00000304 00000000 0000000A 1 14 00000308 0 00000000 0 0
28 0020A623 00000400 00000000 00000404 0 0 00000000 1 00000011 0 0
29 00008783 00000404 000000F0 00000408 1 15 FFFFFFF0 0 00000000 0 0
30 0000C803 00000408 123456F0 0000040C 1 16 000000F0 0 00000000 0 0
31 00009883 0000040C 00008001 00000410 1 17 FFFF8001 0 00000000 0 0
32 0000A903 00000410 CAFEBABE 00000414 1 18 CAFEBABE 0 00000000 0 0
33 01078A33 00000414 00000000 00000418 1 20 000000E0 0 00000000 0 0
34 00708013 00000418 00000000 0000041C 0 0 00000000 0 00000000 0 0
35 001009B3 0000041C 00000000 00000420 1 19 00000005 0 00000000 0 0
36 FFFFFFFF 00000500 00000000 00000504 0 0 00000000 0 00000000 1 0
37 00100073 00000504 00000000 00000508 0 0 00000000 0 00000000 0 1
38 000F8AB3 00000508 00000000 0000050C 1 21 00000000 0 00000000 0 0

/* verification/rvCore_props.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module rvCore_props (
    input wire logic                   clk,
    input wire logic                   arstN,
    input wire logic                   instValid,
    input wire logic                   resValid,
    input wire logic                   wbEn,
    input wire logic [`REG_ADDR_W-1:0] wbAddr,
    input wire logic                   memWrEn,
    input wire logic                   memRdEn,
    input wire logic                   illegal,
    input wire logic                   halt
);

    int propErrors = 0;

    // one result per instruction, exactly one cycle later
    resultLatency: assert property (
        @(posedge clk) disable iff (!arstN) resValid == $past(instValid)
    ) else begin
        $error("resValid does not follow instValid by one cycle");
        propErrors++;
    end

    // traps never write anything
    trapNoWrite: assert property (
        @(posedge clk) disable iff (!arstN) (illegal || halt) |-> !(wbEn || memWrEn)
    ) else begin
        $error("register or memory write together with illegal or halt");
        propErrors++;
    end

    noZeroWrite: assert property (
        @(posedge clk) disable iff (!arstN) wbEn |-> wbAddr != '0
    ) else begin
        $error("writeback reported for register x0");
        propErrors++;
    end

    quietInReset: assert property (
        @(posedge clk) !arstN |-> !(resValid || wbEn || memWrEn || memRdEn || illegal || halt)
    ) else begin
        $error("control output high during reset");
        propErrors++;
    end

endmodule

bind rvCore rvCore_props uProps (
    .clk(clk), .arstN(arstN), .instValid(instValid), .resValid(resValid),
    .wbEn(wbEn), .wbAddr(wbAddr), .memWrEn(memWrEn), .memRdEn(memRdEn),
    .illegal(illegal), .halt(halt)
);

`default_nettype wire

/* verification/rvCore_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module rvCore_tb;

    localparam int TimeoutCycles = 20;

    // RV32I major opcodes that start a memory access
    localparam logic [6:0] LoadOpcode  = 7'b0000011;
    localparam logic [6:0] StoreOpcode = 7'b0100011;

    logic                   clk;
    logic                   arstN;
    logic                   instValid;
    logic [31:0]            inst;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       loadData;
    logic                   resValid;
    logic [`XLEN-1:0]       pcNext;
    logic                   wbEn;
    logic [`REG_ADDR_W-1:0] wbAddr;
    logic [`XLEN-1:0]       wbData;
    logic                   memWrEn;
    logic                   memRdEn;
    logic [`XLEN-1:0]       memAddr;
    logic [`XLEN-1:0]       memWdata;
    logic [2:0]             memFmt;
    logic                   illegal;
    logic                   halt;

    // register contents as the expected writebacks leave them
    logic [31:0] shadowRegs [32];

    int passCount;
    int failCount;
    int fieldErrors;

    rvCore UUT (
        .clk(clk), .arstN(arstN), .instValid(instValid), .inst(inst), .pc(pc),
        .loadData(loadData), .resValid(resValid), .pcNext(pcNext), .wbEn(wbEn),
        .wbAddr(wbAddr), .wbData(wbData), .memWrEn(memWrEn), .memRdEn(memRdEn),
        .memAddr(memAddr), .memWdata(memWdata), .memFmt(memFmt),
        .illegal(illegal), .halt(halt)
    );

    always #4 clk = ~clk;

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp, input int id);
        assert (got === exp) else begin
            $display("mismatch at %0t ns: test %0d %s is %h, expected %h",
                     $time, id, name, got, exp);
            fieldErrors++;
        end
    endtask

    // polls on falling edges and drops the strobe while waiting
    task automatic waitResult(output bit seen);
        int cycles;
        cycles = 0;
        while (resValid !== 1'b1 && cycles < TimeoutCycles) begin
            instValid = 1'b0;
            @(negedge clk);
            cycles++;
        end
        seen = (resValid === 1'b1);
    endtask

    initial begin
        int          fd;
        int          id;
        int          fields;
        string       line;
        logic [31:0] vInst;
        logic [31:0] vPc;
        logic [31:0] vLoad;
        logic [31:0] ePcNext;
        logic [31:0] eWbData;
        logic [31:0] eMemAddr;
        int          eWbEn;
        int          eWbAddr;
        int          eMemWrEn;
        int          eIllegal;
        int          eHalt;
        logic        eMemRdEn;
        bit          seen;

        clk       = 1'b0;
        arstN     = 1'b1;
        instValid = 1'b0;
        inst      = '0;
        pc        = '0;
        loadData  = '0;
        passCount = 0;
        failCount = 0;
        foreach (shadowRegs[i]) begin
            shadowRegs[i] = '0;
        end

        #1 arstN = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        fd = $fopen("verification/rvCore_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file verification/rvCore_input.txt");
            failCount++;
        end

        @(negedge clk);
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            fields = $sscanf(line, "%d %h %h %h %h %d %d %h %d %h %d %d",
                             id, vInst, vPc, vLoad, ePcNext, eWbEn, eWbAddr,
                             eWbData, eMemWrEn, eMemAddr, eIllegal, eHalt);
            if (fields != 12) begin
                $display("vector line could not be parsed: %s", line);
                failCount++;
                continue;
            end
            eMemRdEn = (vInst[6:0] == LoadOpcode);

            // next vector goes out on the same edge the last result is checked
            inst      = vInst;
            pc        = vPc;
            loadData  = vLoad;
            instValid = 1'b1;
            @(negedge clk);
            waitResult(seen);
            if (!seen) begin
                $display("test %0d: resValid did not rise within %0d cycles",
                         id, TimeoutCycles);
                failCount++;
                break;
            end

            fieldErrors = 0;
            compareField("pcNext", pcNext, ePcNext, id);
            compareField("wbEn", wbEn, eWbEn, id);
            if (eWbEn != 0) begin
                compareField("wbAddr", wbAddr, eWbAddr, id);
                compareField("wbData", wbData, eWbData, id);
            end
            compareField("memWrEn", memWrEn, eMemWrEn, id);
            if (eMemWrEn != 0) begin
                compareField("memAddr", memAddr, eMemAddr, id);
                compareField("memWdata", memWdata, shadowRegs[vInst[24:20]], id);
            end
            compareField("memRdEn", memRdEn, eMemRdEn, id);
            if (eMemRdEn || vInst[6:0] == StoreOpcode) begin
                compareField("memFmt", memFmt, vInst[14:12], id);
            end
            compareField("illegal", illegal, eIllegal, id);
            compareField("halt", halt, eHalt, id);

            if (eWbEn != 0 && eWbAddr != 0) begin
                shadowRegs[eWbAddr] = eWbData;
            end

            if (fieldErrors == 0) begin
                passCount++;
                $display("test %0d passed", id);
            end else begin
                failCount++;
                $display("test %0d failed with %0d mismatches", id, fieldErrors);
            end
        end
        instValid = 1'b0;
        if (fd != 0) begin
            $fclose(fd);
        end

        // let the bound checks see the last result
        repeat (2) @(negedge clk);
        $display("tests passed: %0d, tests failed: %0d, property failures: %0d",
                 passCount, failCount, UUT.uProps.propErrors);
        if (failCount == 0 && passCount > 0 && UUT.uProps.propErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
